// ==== Makefile ====
# Verilator build and run for the IBI controller

VERILATOR ?= verilator
TOP       ?= ibi_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, fail if the log reports failure"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

test: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi
	@grep -q "RESULT: PASS" $(LOG) || (echo "No result in log"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== common/ibi_bus_pkg.sv ====
`include "ibi_macros.svh"

package ibi_bus_pkg;

    // Serializer transmit modes
    typedef enum logic [`IBI_MODE_W-1:0]
    {
        REP_START = 3'd0,
        SERIAL    = 3'd1,   // Shift out a byte from the register file
        STOP      = 3'd2,
        PARITY    = 3'd3,   // T-bit after a transmitted byte
        DRIVE_LOW = 3'd4
    } ser_mode_e;

    // Deserializer receive modes
    typedef enum logic [`IBI_MODE_W-1:0]
    {
        RX_ACK   = 3'd0,    // Sample one ACK bit
        RX_DESER = 3'd1     // Shift in a byte
    } rx_mode_e;

    // Control word to the serializer and deserializer
    typedef struct packed
    {
        logic      tx_en;
        logic      rx_en;
        ser_mode_e tx_mode;
        rx_mode_e  rx_mode;
        logic      pp_od;       // 1 push-pull, 0 open drain
        logic      cnt_en;      // Bit counter enable
        logic      ser_rx_tx;   // Bus owned by the payload engine
    } ser_ctrl_t;

endpackage

// ==== common/ibi_ctrl_pkg.sv ====
package ibi_ctrl_pkg;

    // Configuration byte from the register file
    typedef struct packed
    {
        logic [3:0] reserved;
        logic [1:0] disable_sel;   // Outcome of a NACK
        logic       payload_rd;    // Read payload after the MDB
        logic       ack_en;        // ACK the IBI request
    } ibi_cfg_t;

    // Source of the register file address
    typedef enum logic [2:0]
    {
        SEL_HOLD,
        SEL_BCR,
        SEL_MDB,
        SEL_BDCST,
        SEL_DISEC_BDCST,
        SEL_DISEC_BYTE
    } addr_sel_e;

    typedef struct packed
    {
        addr_sel_e addr_sel;
        logic      rd_en;
        logic      wr_req;   // Level, shaped into a pulse by the port
    } regf_req_t;

    typedef enum logic [3:0]
    {
        IDLE,
        ACK,
        NACK,
        MDB,
        MDB_T_BIT,
        PAYLOAD,
        REP_START,
        BDCST,
        TGT_ACK,
        DISEC_CCC,
        PARITY,
        DISEC_BYTE,
        STOP
    } ibi_state_e;

endpackage

// ==== common/ibi_macros.svh ====
`ifndef IBI_MACROS_SVH
`define IBI_MACROS_SVH

//////////////////////////////
// BCR location of a target
//////////////////////////////

// BCR address = base + offset + stride * (tgt[7:1] - first target)
`define IBI_FIRST_TGT_ADDR    7'h08
`define IBI_BCR_BASE          10'd200
`define IBI_BCR_OFFSET        10'd6
`define IBI_TGT_STRIDE        10'd8

//////////////////////////////
// Register file map
//////////////////////////////

`define IBI_REGF_AW           10
`define IBI_MDB_ADDR          10'd107   // Mandatory data byte
`define IBI_BDCST_ADDR        10'd46    // Broadcast address 7'h7E, write
`define IBI_DISEC_BDCST_ADDR  10'd104   // Broadcast DISEC command code
`define IBI_DISEC_BYTE_ADDR   10'd392   // Events to disable

//////////////////////////////
// Field widths and codes
//////////////////////////////

`define IBI_BYTE_W            8
`define IBI_MODE_W            3

// NACK outcome in cfg[3:2] that disables all targets
`define IBI_NACK_DISEC_ALL    2'b11

`endif

// ==== ibi/ibi_fsm.sv ====
`timescale 1ns/100ps
`include "ibi_macros.svh"

module ibi_fsm
(
    input  logic                    i_ibi_clk,
    input  logic                    i_ibi_rst_n,
    input  logic                    i_ibi_en,
    input  logic                    i_scl,
    input  logic                    i_scl_neg_edge,
    input  ibi_ctrl_pkg::ibi_cfg_t  i_cfg,
    input  logic                    i_bcr_bit2,
    input  logic                    i_ack_nack,
    input  logic                    i_payload_done,
    input  logic                    i_ser_done_pulse,
    input  logic                    i_ser_done_d1,
    input  logic                    i_ser_done_d2,
    input  logic                    i_ser_done_d3,
    input  logic                    i_rx_done_d1,
    input  logic                    i_rx_done_d2,
    output ibi_bus_pkg::ser_ctrl_t  o_ser,
    output ibi_ctrl_pkg::regf_req_t o_regf_req,
    output logic                    o_payload_en,
    output logic                    o_done
);

    ibi_ctrl_pkg::ibi_state_e state;
    logic                     parity_last;     // Parity of the disable byte, STOP follows
    logic                     ser_done_held;

    // Done rose two cycles ago and is still high
    assign ser_done_held = i_ser_done_d1 & i_ser_done_d2 & ~i_ser_done_d3;

    always_ff @(posedge i_ibi_clk or negedge i_ibi_rst_n)
    begin
        if (!i_ibi_rst_n)
        begin
            state        <= ibi_ctrl_pkg::IDLE;
            o_ser        <= '0;
            o_regf_req   <= '0;
            o_payload_en <= 1'b0;
            o_done       <= 1'b0;
            parity_last  <= 1'b0;
        end
        else
        begin
            o_done <= 1'b0;
            case (state)
                ibi_ctrl_pkg::IDLE:
                begin
                    if (i_ibi_en && i_scl_neg_edge)   // Request seen, ACK bit starts
                    begin
                        o_ser.pp_od <= 1'b0;
                        if (i_cfg.ack_en)
                        begin
                            state               <= ibi_ctrl_pkg::ACK;
                            o_ser.tx_en         <= 1'b1;
                            o_ser.tx_mode       <= ibi_bus_pkg::DRIVE_LOW;
                            o_regf_req.addr_sel <= ibi_ctrl_pkg::SEL_BCR;
                            o_regf_req.rd_en    <= 1'b1;
                        end
                        else
                        begin
                            state       <= ibi_ctrl_pkg::NACK;   // SDA left high
                            o_ser.tx_en <= 1'b0;
                        end
                    end
                end

                //////////////////////////////
                // ACK path
                //////////////////////////////

                ibi_ctrl_pkg::ACK:
                begin
                    if (i_scl)
                    begin
                        if (i_bcr_bit2)   // Target sends an MDB
                        begin
                            state            <= ibi_ctrl_pkg::MDB;
                            o_regf_req.rd_en <= 1'b0;
                            o_ser.tx_en      <= 1'b0;
                            o_ser.rx_en      <= 1'b1;
                            o_ser.rx_mode    <= ibi_bus_pkg::RX_DESER;
                            o_ser.pp_od      <= 1'b1;
                            o_ser.cnt_en     <= 1'b1;
                        end
                        else
                        begin
                            state <= ibi_ctrl_pkg::STOP;
                        end
                    end
                end

                ibi_ctrl_pkg::MDB:
                begin
                    if (i_rx_done_d1)
                        o_regf_req.wr_req <= 1'b1;
                    if (i_rx_done_d2)
                    begin
                        o_regf_req.addr_sel <= ibi_ctrl_pkg::SEL_MDB;
                        if (!i_scl)
                        begin
                            state         <= ibi_ctrl_pkg::MDB_T_BIT;
                            o_ser.rx_en   <= 1'b0;
                            o_ser.cnt_en  <= 1'b0;
                            o_ser.tx_mode <= ibi_bus_pkg::DRIVE_LOW;
                        end
                    end
                end

                ibi_ctrl_pkg::MDB_T_BIT:
                begin
                    o_regf_req.wr_req <= 1'b0;
                    if (i_cfg.payload_rd)
                    begin
                        state           <= ibi_ctrl_pkg::PAYLOAD;
                        o_payload_en    <= 1'b1;
                        o_ser.ser_rx_tx <= 1'b1;
                    end
                    else if (i_scl)
                    begin
                        state       <= ibi_ctrl_pkg::STOP;
                        o_ser.tx_en <= 1'b1;
                    end
                end

                ibi_ctrl_pkg::PAYLOAD:
                begin
                    if (i_payload_done)
                    begin
                        state           <= ibi_ctrl_pkg::STOP;
                        o_payload_en    <= 1'b0;
                        o_ser.ser_rx_tx <= 1'b0;
                    end
                end

                //////////////////////////////
                // NACK path, broadcast DISEC
                //////////////////////////////

                ibi_ctrl_pkg::NACK:
                begin
                    if (i_scl)
                    begin
                        if (i_cfg.disable_sel == `IBI_NACK_DISEC_ALL)
                        begin
                            state         <= ibi_ctrl_pkg::REP_START;
                            o_ser.tx_en   <= 1'b1;
                            o_ser.pp_od   <= 1'b1;
                            o_ser.tx_mode <= ibi_bus_pkg::REP_START;
                        end
                        else
                        begin
                            state <= ibi_ctrl_pkg::STOP;   // Target stays enabled
                        end
                    end
                end

                ibi_ctrl_pkg::REP_START:
                begin
                    if (ser_done_held)
                    begin
                        state               <= ibi_ctrl_pkg::BDCST;
                        o_ser.tx_mode       <= ibi_bus_pkg::SERIAL;
                        o_ser.cnt_en        <= 1'b1;
                        o_regf_req.addr_sel <= ibi_ctrl_pkg::SEL_BDCST;
                        o_regf_req.rd_en    <= 1'b1;
                    end
                end

                ibi_ctrl_pkg::BDCST:
                begin
                    if (ser_done_held)   // Low SCL of the last address bit
                    begin
                        state         <= ibi_ctrl_pkg::TGT_ACK;
                        o_ser.tx_en   <= 1'b0;
                        o_ser.pp_od   <= 1'b0;
                        o_ser.cnt_en  <= 1'b0;
                        o_ser.rx_en   <= 1'b1;
                        o_ser.rx_mode <= ibi_bus_pkg::RX_ACK;
                    end
                end

                ibi_ctrl_pkg::TGT_ACK:
                begin
                    if (i_scl)
                    begin
                        o_ser.rx_en <= 1'b0;
                        if (i_ack_nack)
                        begin
                            state               <= ibi_ctrl_pkg::DISEC_CCC;
                            o_ser.cnt_en        <= 1'b1;
                            o_regf_req.addr_sel <= ibi_ctrl_pkg::SEL_DISEC_BDCST;
                        end
                        else
                        begin
                            state <= ibi_ctrl_pkg::STOP;
                        end
                    end
                end

                ibi_ctrl_pkg::DISEC_CCC:
                begin
                    if (ser_done_held)
                    begin
                        state               <= ibi_ctrl_pkg::PARITY;
                        o_ser.cnt_en        <= 1'b0;
                        o_ser.tx_mode       <= ibi_bus_pkg::PARITY;
                        o_regf_req.addr_sel <= ibi_ctrl_pkg::SEL_DISEC_BYTE;
                        parity_last         <= 1'b0;
                    end
                    else if (!i_scl)   // Take SDA back after the target ACK
                    begin
                        o_ser.tx_en   <= 1'b1;
                        o_ser.pp_od   <= 1'b1;
                        o_ser.tx_mode <= ibi_bus_pkg::SERIAL;
                    end
                end

                ibi_ctrl_pkg::PARITY:
                begin
                    if (i_ser_done_pulse)
                    begin
                        if (parity_last)
                        begin
                            state <= ibi_ctrl_pkg::STOP;
                        end
                        else
                        begin
                            state         <= ibi_ctrl_pkg::DISEC_BYTE;
                            o_ser.tx_mode <= ibi_bus_pkg::SERIAL;
                            o_ser.cnt_en  <= 1'b1;
                        end
                    end
                end

                ibi_ctrl_pkg::DISEC_BYTE:
                begin
                    if (i_ser_done_pulse)
                    begin
                        state         <= ibi_ctrl_pkg::PARITY;
                        o_ser.tx_mode <= ibi_bus_pkg::PARITY;
                        o_ser.cnt_en  <= 1'b0;
                        parity_last   <= 1'b1;
                    end
                end

                ibi_ctrl_pkg::STOP:
                begin
                    o_regf_req.rd_en    <= 1'b0;
                    o_regf_req.addr_sel <= ibi_ctrl_pkg::SEL_HOLD;
                    if (i_ser_done_pulse && o_ser.tx_en &&
                        o_ser.tx_mode == ibi_bus_pkg::STOP)
                    begin
                        state       <= ibi_ctrl_pkg::IDLE;
                        o_done      <= 1'b1;
                        o_ser.tx_en <= 1'b0;
                        o_ser.pp_od <= 1'b0;
                    end
                    else if (!i_scl)
                    begin
                        o_ser.tx_en   <= 1'b1;
                        o_ser.tx_mode <= ibi_bus_pkg::STOP;
                    end
                end

                default:
                    state <= ibi_ctrl_pkg::IDLE;
            endcase
        end
    end

    // Serializer and deserializer never drive at once
    a_tx_rx_excl : assert property (@(posedge i_ibi_clk) disable iff (!i_ibi_rst_n)
        !(o_ser.tx_en && o_ser.rx_en));

endmodule

// ==== ibi/ibi_top.sv ====
`timescale 1ns/100ps
`include "ibi_macros.svh"

module ibi_top
(
    input  logic                    i_ibi_clk,
    input  logic                    i_ibi_rst_n,
    input  logic                    i_ibi_en,
    input  logic                    i_ibi_scl,
    input  logic                    i_ibi_scl_neg_edge,
    input  logic                    i_ibi_scl_pos_edge,
    input  logic [`IBI_BYTE_W-1:0]  i_ibi_cfg_reg,
    input  logic [`IBI_BYTE_W-1:0]  i_ibi_bcr_reg,
    input  logic [`IBI_BYTE_W-1:0]  i_ibi_tgt_address,
    input  logic                    i_ibi_ser_mode_done,
    input  logic                    i_ibi_rx_mode_done,
    input  logic                    i_ibi_payload_done,
    input  logic                    i_ibi_ack_nack,
    output ibi_bus_pkg::ser_ctrl_t  o_ibi_ser,
    output logic [`IBI_REGF_AW-1:0] o_ibi_regf_address,
    output logic                    o_ibi_regf_rd_en,
    output logic                    o_ibi_regf_wr_en,
    output logic                    o_ibi_payload_en,
    output logic                    o_ibi_done
);

    ibi_ctrl_pkg::ibi_cfg_t  cfg;
    ibi_ctrl_pkg::regf_req_t regf_req;
    logic                    ser_done_pulse;
    logic                    ser_done_d1;
    logic                    ser_done_d2;
    logic                    ser_done_d3;
    logic                    rx_done_d1;
    logic                    rx_done_d2;

    assign cfg = ibi_ctrl_pkg::ibi_cfg_t'(i_ibi_cfg_reg);

    ibi_done_shaper u_done_shaper
    (
        .i_ibi_clk        (i_ibi_clk),
        .i_ibi_rst_n      (i_ibi_rst_n),
        .i_ser_mode_done  (i_ibi_ser_mode_done),
        .i_rx_mode_done   (i_ibi_rx_mode_done),
        .o_ser_done_pulse (ser_done_pulse),
        .o_ser_done_d1    (ser_done_d1),
        .o_ser_done_d2    (ser_done_d2),
        .o_ser_done_d3    (ser_done_d3),
        .o_rx_done_d1     (rx_done_d1),
        .o_rx_done_d2     (rx_done_d2)
    );

    ibi_fsm u_fsm
    (
        .i_ibi_clk        (i_ibi_clk),
        .i_ibi_rst_n      (i_ibi_rst_n),
        .i_ibi_en         (i_ibi_en),
        .i_scl            (i_ibi_scl),
        .i_scl_neg_edge   (i_ibi_scl_neg_edge),
        .i_cfg            (cfg),
        .i_bcr_bit2       (i_ibi_bcr_reg[2]),   // MDB follows the IBI
        .i_ack_nack       (i_ibi_ack_nack),
        .i_payload_done   (i_ibi_payload_done),
        .i_ser_done_pulse (ser_done_pulse),
        .i_ser_done_d1    (ser_done_d1),
        .i_ser_done_d2    (ser_done_d2),
        .i_ser_done_d3    (ser_done_d3),
        .i_rx_done_d1     (rx_done_d1),
        .i_rx_done_d2     (rx_done_d2),
        .o_ser            (o_ibi_ser),
        .o_regf_req       (regf_req),
        .o_payload_en     (o_ibi_payload_en),
        .o_done           (o_ibi_done)
    );

    ibi_regf_port u_regf_port
    (
        .i_ibi_clk      (i_ibi_clk),
        .i_ibi_rst_n    (i_ibi_rst_n),
        .i_req          (regf_req),
        .i_tgt_address  (i_ibi_tgt_address),
        .o_regf_address (o_ibi_regf_address),
        .o_regf_rd_en   (o_ibi_regf_rd_en),
        .o_regf_wr_en   (o_ibi_regf_wr_en)
    );

    // The FSM relies on distinct SCL edge strobes
    a_scl_strobes : assert property (@(posedge i_ibi_clk) disable iff (!i_ibi_rst_n)
        !(i_ibi_scl_neg_edge && i_ibi_scl_pos_edge));

endmodule

// ==== logic/ibi_done_shaper.sv ====
`timescale 1ns/100ps

module ibi_done_shaper
(
    input  logic i_ibi_clk,
    input  logic i_ibi_rst_n,
    input  logic i_ser_mode_done,
    input  logic i_rx_mode_done,
    output logic o_ser_done_pulse,
    output logic o_ser_done_d1,
    output logic o_ser_done_d2,
    output logic o_ser_done_d3,
    output logic o_rx_done_d1,
    output logic o_rx_done_d2
);

    //////////////////////////////
    // Serializer done
    //////////////////////////////

    always_ff @(posedge i_ibi_clk or negedge i_ibi_rst_n)
    begin
        if (!i_ibi_rst_n)
        begin
            o_ser_done_pulse <= 1'b0;
            o_ser_done_d1    <= 1'b0;
            o_ser_done_d2    <= 1'b0;
            o_ser_done_d3    <= 1'b0;
        end
        else
        begin
            // d1 still holds the previous level here
            o_ser_done_pulse <= i_ser_mode_done & ~o_ser_done_d1;
            o_ser_done_d1    <= i_ser_mode_done;
            o_ser_done_d2    <= o_ser_done_d1;
            o_ser_done_d3    <= o_ser_done_d2;
        end
    end

    //////////////////////////////
    // Deserializer done
    //////////////////////////////

    always_ff @(posedge i_ibi_clk or negedge i_ibi_rst_n)
    begin
        if (!i_ibi_rst_n)
        begin
            o_rx_done_d1 <= 1'b0;
            o_rx_done_d2 <= 1'b0;
        end
        else
        begin
            o_rx_done_d1 <= i_rx_mode_done;
            o_rx_done_d2 <= o_rx_done_d1;
        end
    end

    // A held done level must not retrigger the edge detector
    a_pulse_single : assert property (@(posedge i_ibi_clk) disable iff (!i_ibi_rst_n)
        o_ser_done_pulse |=> !o_ser_done_pulse);

endmodule

// ==== logic/ibi_regf_port.sv ====
`timescale 1ns/100ps
`include "ibi_macros.svh"

module ibi_regf_port
(
    input  logic                     i_ibi_clk,
    input  logic                     i_ibi_rst_n,
    input  ibi_ctrl_pkg::regf_req_t  i_req,
    input  logic [`IBI_BYTE_W-1:0]   i_tgt_address,
    output logic [`IBI_REGF_AW-1:0]  o_regf_address,
    output logic                     o_regf_rd_en,
    output logic                     o_regf_wr_en
);

    logic [`IBI_REGF_AW-1:0] tgt_index;
    logic [`IBI_REGF_AW-1:0] bcr_addr;
    logic [`IBI_REGF_AW-1:0] next_addr;
    logic                    wr_q1;
    logic                    wr_q2;

    // Dynamic address, bit 0 of the target address is the RnW bit
    assign tgt_index = `IBI_REGF_AW'(i_tgt_address[7:1]) - `IBI_REGF_AW'(`IBI_FIRST_TGT_ADDR);
    assign bcr_addr  = `IBI_BCR_BASE + `IBI_BCR_OFFSET + tgt_index * `IBI_TGT_STRIDE;

    always_comb
    begin
        case (i_req.addr_sel)
            ibi_ctrl_pkg::SEL_BCR:         next_addr = bcr_addr;
            ibi_ctrl_pkg::SEL_MDB:         next_addr = `IBI_MDB_ADDR;
            ibi_ctrl_pkg::SEL_BDCST:       next_addr = `IBI_BDCST_ADDR;
            ibi_ctrl_pkg::SEL_DISEC_BDCST: next_addr = `IBI_DISEC_BDCST_ADDR;
            ibi_ctrl_pkg::SEL_DISEC_BYTE:  next_addr = `IBI_DISEC_BYTE_ADDR;
            default:                       next_addr = o_regf_address;   // HOLD
        endcase
    end

    //////////////////////////////
    // Address and strobes
    //////////////////////////////

    always_ff @(posedge i_ibi_clk or negedge i_ibi_rst_n)
    begin
        if (!i_ibi_rst_n)
        begin
            o_regf_address <= '0;
            o_regf_rd_en   <= 1'b0;
            wr_q1          <= 1'b0;
            wr_q2          <= 1'b0;
            o_regf_wr_en   <= 1'b0;
        end
        else
        begin
            o_regf_address <= next_addr;
            o_regf_rd_en   <= i_req.rd_en;
            wr_q1          <= i_req.wr_req;
            wr_q2          <= wr_q1;
            o_regf_wr_en   <= wr_q1 & ~wr_q2;   // Rising edge, two cycles late
        end
    end

    a_wr_single : assert property (@(posedge i_ibi_clk) disable iff (!i_ibi_rst_n)
        o_regf_wr_en |=> !o_regf_wr_en);

endmodule

// ==== sources.f ====
+incdir+common
+incdir+verif
common/ibi_bus_pkg.sv
common/ibi_ctrl_pkg.sv
logic/ibi_done_shaper.sv
logic/ibi_regf_port.sv
ibi/ibi_fsm.sv
ibi/ibi_top.sv
verif/ibi_tb.sv

// ==== verif/ibi_tb_bus.svh ====
`ifndef IBI_TB_BUS_SVH
`define IBI_TB_BUS_SVH

//////////////////////////////
// SCL and bus responders
//////////////////////////////

// SCL at clk/8 with one-cycle edge strobes
task automatic run_scl();
    int phase;
    phase = 0;
    forever
    begin
        @(negedge clk);
        if (!rst_n)
        begin
            phase   = 0;
            scl     = 1'b1;
            scl_neg = 1'b0;
            scl_pos = 1'b0;
        end
        else
        begin
            scl_neg = (phase == 0);
            scl_pos = (phase == 4);
            if (phase == 0)
                scl = 1'b0;
            if (phase == 4)
                scl = 1'b1;
            phase = (phase + 1) % 8;
        end
    end
endtask

// One done level per new transmit mode, DRIVE_LOW needs no answer
task automatic answer_ser();
    logic                   active;
    ibi_bus_pkg::ser_mode_e last;
    ibi_bus_pkg::ser_mode_e mode;
    int                     bits;
    active = 1'b0;
    last   = ibi_bus_pkg::REP_START;
    forever
    begin
        @(negedge clk);
        if (!ser.tx_en)
            active = 1'b0;
        else if (ser.tx_mode != ibi_bus_pkg::DRIVE_LOW && (!active || ser.tx_mode != last))
        begin
            mode = ser.tx_mode;
            bits = 1 + int'($unsigned($random(seed)) % 3);
            repeat (bits * 8)
            begin
                @(negedge clk);
                // The mode stays put until its done arrives
                check_true("serializer mode dropped before its done",
                           ser.tx_en && ser.tx_mode == mode);
            end
            ser_done = 1'b1;
            repeat (4) @(negedge clk);   // Long enough for the held-done check
            ser_done = 1'b0;
            active   = 1'b1;
            last     = mode;
        end
    end
endtask

// Byte receive answers after some bits, level held while rx_en stays high
task automatic answer_rx();
    int bits;
    forever
    begin
        @(negedge clk);
        if (ser.rx_en && ser.rx_mode == ibi_bus_pkg::RX_DESER)
        begin
            bits = 1 + int'($unsigned($random(seed)) % 3);
            repeat (bits * 8) @(negedge clk);
            rx_done = 1'b1;
            while (ser.rx_en)
                @(negedge clk);
            rx_done = 1'b0;
        end
    end
endtask

task automatic answer_payload();
    int wait_cyc;
    forever
    begin
        @(negedge clk);
        if (pay_en)
        begin
            wait_cyc = 4 + int'($unsigned($random(seed)) % 16);
            repeat (wait_cyc) @(negedge clk);
            pay_done = 1'b1;
            while (pay_en)
                @(negedge clk);
            pay_done = 1'b0;
        end
    end
endtask

`endif

// ==== verif/ibi_tb.sv ====
`timescale 1ns/100ps
`include "ibi_macros.svh"

module ibi_tb;

    localparam int NUM_ROWS = 9;

    typedef struct packed
    {
        logic [7:0] tgt;
        logic [7:0] cfg;
        logic [7:0] bcr;
        logic       ack;       // Target ACK in the broadcast phase
        logic [1:0] n_rd;
        logic [9:0] rd0;
        logic [9:0] rd1;
        logic [9:0] rd2;
        logic [1:0] n_wr;
        logic       payload;
    } row_t;

    logic                   clk;
    logic                   rst_n;
    logic                   en;
    logic                   scl;
    logic                   scl_neg;
    logic                   scl_pos;
    logic [7:0]             cfg;
    logic [7:0]             bcr;
    logic [7:0]             tgt;
    logic                   ser_done;
    logic                   rx_done;
    logic                   pay_done;
    logic                   ack_nack;
    ibi_bus_pkg::ser_ctrl_t ser;
    logic [9:0]             regf_addr;
    logic                   rd_en;
    logic                   wr_en;
    logic                   pay_en;
    logic                   done;

    integer     seed = 32'h67901b45;
    row_t       rows [NUM_ROWS];
    logic [9:0] rd_seen [$];
    int         wr_cnt;
    int         done_cnt;
    bit         saw_stop;
    bit         saw_pay;

    ibi_top dut
    (
        .i_ibi_clk           (clk),
        .i_ibi_rst_n         (rst_n),
        .i_ibi_en            (en),
        .i_ibi_scl           (scl),
        .i_ibi_scl_neg_edge  (scl_neg),
        .i_ibi_scl_pos_edge  (scl_pos),
        .i_ibi_cfg_reg       (cfg),
        .i_ibi_bcr_reg       (bcr),
        .i_ibi_tgt_address   (tgt),
        .i_ibi_ser_mode_done (ser_done),
        .i_ibi_rx_mode_done  (rx_done),
        .i_ibi_payload_done  (pay_done),
        .i_ibi_ack_nack      (ack_nack),
        .o_ibi_ser           (ser),
        .o_ibi_regf_address  (regf_addr),
        .o_ibi_regf_rd_en    (rd_en),
        .o_ibi_regf_wr_en    (wr_en),
        .o_ibi_payload_en    (pay_en),
        .o_ibi_done          (done)
    );

    `include "ibi_tb_bus.svh"

    always #4 clk = ~clk;

    //////////////////////////////
    // Checks
    //////////////////////////////

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp)
        else
        begin
            $display("ERR %s got 0x%0h expected 0x%0h", name, got, exp);
            $display("RESULT: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic check_true(input string what, input bit cond);
        assert (cond)
        else
        begin
            $display("Check failed: %s", what);
            $display("RESULT: FAIL");
            $fatal(1, "check failed");
        end
    endtask

    task automatic apply_row(input row_t r);
        logic [9:0] last_addr;
        logic       last_rd;
        bit         finished;
        int         tail;
        logic [9:0] exp_rd [3];
        rd_seen.delete();
        wr_cnt    = 0;
        done_cnt  = 0;
        saw_stop  = 0;
        saw_pay   = 0;
        last_rd   = 1'b0;
        last_addr = '0;
        finished  = 0;
        tail      = 0;
        exp_rd[0] = r.rd0;
        exp_rd[1] = r.rd1;
        exp_rd[2] = r.rd2;
        @(negedge clk);
        tgt      = r.tgt;
        cfg      = r.cfg;
        bcr      = r.bcr;
        ack_nack = r.ack;
        en       = 1'b1;
        do
            @(posedge clk);
        while (!scl_neg);   // FSM takes the request on this edge
        while (tail < 16)
        begin
            @(negedge clk);
            en = 1'b0;
            if (rd_en && (!last_rd || regf_addr != last_addr))
                rd_seen.push_back(regf_addr);
            last_rd   = rd_en;
            last_addr = regf_addr;
            if (wr_en)
            begin
                wr_cnt++;
                check_value("o_ibi_regf_address", 32'(regf_addr), 32'(`IBI_MDB_ADDR));
            end
            if (ser.tx_en && ser.tx_mode == ibi_bus_pkg::STOP)
                saw_stop = 1;
            if (pay_en)
                saw_pay = 1;
            if (done)
            begin
                done_cnt++;
                finished = 1;
                check_value("o_ibi_payload_en", 32'(pay_en), 32'h0);
            end
            if (finished)
                tail++;
        end
        check_value("o_ibi_regf_rd_en count", rd_seen.size(), 32'(r.n_rd));
        for (int i = 0; i < int'(r.n_rd); i++)
            check_value("o_ibi_regf_address read", 32'(rd_seen[i]), 32'(exp_rd[i]));
        check_value("o_ibi_regf_wr_en count", wr_cnt, 32'(r.n_wr));
        check_value("o_ibi_done count", done_cnt, 32'h1);
        check_true("no STOP was issued before done", saw_stop);
        check_value("o_ibi_payload_en seen", 32'(saw_pay), 32'(r.payload));
    endtask

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    initial
    begin
        clk      = 1'b0;
        rst_n    = 1'b0;
        en       = 1'b0;
        scl      = 1'b1;
        scl_neg  = 1'b0;
        scl_pos  = 1'b0;
        cfg      = '0;
        bcr      = '0;
        tgt      = '0;
        ser_done = 1'b0;
        rx_done  = 1'b0;
        pay_done = 1'b0;
        ack_nack = 1'b0;

        //         tgt    cfg    bcr    ack   n  rd0     rd1     rd2     wr    pay
        rows[0] = '{8'h10, 8'h01, 8'h00, 1'b0, 2'd1, 10'd206, 10'd0, 10'd0, 2'd0, 1'b0};
        rows[1] = '{8'h12, 8'h01, 8'h00, 1'b0, 2'd1, 10'd214, 10'd0, 10'd0, 2'd0, 1'b0};
        rows[2] = '{8'h16, 8'h01, 8'h00, 1'b0, 2'd1, 10'd230, 10'd0, 10'd0, 2'd0, 1'b0};
        rows[3] = '{8'h10, 8'h01, 8'h04, 1'b0, 2'd1, 10'd206, 10'd0, 10'd0, 2'd1, 1'b0};
        rows[4] = '{8'h12, 8'h03, 8'h04, 1'b0, 2'd1, 10'd214, 10'd0, 10'd0, 2'd1, 1'b1};
        rows[5] = '{8'h10, 8'h00, 8'h00, 1'b0, 2'd0, 10'd0, 10'd0, 10'd0, 2'd0, 1'b0};
        rows[6] = '{8'h10, 8'h0C, 8'h00, 1'b1, 2'd3, 10'd46, 10'd104, 10'd392, 2'd0, 1'b0};
        rows[7] = '{8'h10, 8'h0C, 8'h00, 1'b0, 2'd1, 10'd46, 10'd0, 10'd0, 2'd0, 1'b0};
        rows[8] = '{8'h12, 8'h04, 8'h04, 1'b1, 2'd0, 10'd0, 10'd0, 10'd0, 2'd0, 1'b0};   // 01 acts as 00

        fork
            run_scl();
            answer_ser();
            answer_rx();
            answer_payload();
        join_none

        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Quiet outputs before any request
        repeat (8)
        begin
            @(negedge clk);
            check_value("o_ibi_done", 32'(done), 32'h0);
            check_value("o_ibi_regf_wr_en", 32'(wr_en), 32'h0);
            check_value("o_ibi_payload_en", 32'(pay_en), 32'h0);
            check_value("o_ibi_ser.tx_en", 32'(ser.tx_en), 32'h0);
            check_value("o_ibi_ser.rx_en", 32'(ser.rx_en), 32'h0);
        end

        for (int i = 0; i < NUM_ROWS; i++)
            apply_row(rows[i]);

        $display("RESULT: PASS");
        $finish;
    end

    initial
    begin
        repeat (NUM_ROWS * 4000) @(posedge clk);
        $display("Timeout, the IBI sequence did not finish in time");
        $display("RESULT: FAIL");
        $fatal(1, "timeout");
    end

endmodule
